//--- common/ctrl_pkg.sv
package ctrl_pkg;

    // major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;

    localparam logic [6:0] F7_SUB     = 7'b0100000;   // funct7 of sub

    typedef enum logic [2:0] {
        CLS_ALU_REG,
        CLS_ALU_IMM,
        CLS_LUI,
        CLS_BRANCH,
        CLS_JAL,
        CLS_NOP,
        CLS_BREAK,
        CLS_ILLEGAL
    } instr_class_e;

    // same codes the datapath ALU decodes
    typedef enum logic [2:0] {
        ALU_NONE = 3'b000,
        ALU_ADD  = 3'b001,
        ALU_SUB  = 3'b010,
        ALU_AND  = 3'b011,
        ALU_SLT  = 3'b110
    } alu_op_e;

    typedef enum logic [1:0] {
        SRC_A_PC   = 2'b00,
        SRC_A_REG  = 2'b01,
        SRC_A_ZERO = 2'b11    // lui path
    } src_a_e;

    typedef enum logic [1:0] {
        SRC_B_REG  = 2'b00,
        SRC_B_FOUR = 2'b01,
        SRC_B_IMM  = 2'b10
    } src_b_e;

    typedef enum logic [1:0] {
        PC_ALU_RESULT  = 2'b01,   // live ALU result
        PC_ALU_OUT     = 2'b00,   // registered ALU-out
        PC_TRAP_VECTOR = 2'b11
    } pc_src_e;

    typedef enum logic [1:0] {
        WB_ALU_OUT = 2'b00,
        WB_PC      = 2'b01,
        WB_ONE     = 2'b10,
        WB_ZERO    = 2'b11
    } wb_sel_e;

    typedef enum logic [3:0] {
        ST_RESET,
        ST_FETCH_WAIT,
        ST_FETCH,
        ST_READ_REGS,
        ST_EXECUTE,
        ST_WRITE_ALU,
        ST_WRITE_ONE,
        ST_WRITE_ZERO,
        ST_JAL_TARGET,
        ST_TRAP_VECTOR,
        ST_HALT
    } state_e;

    typedef struct packed {
        logic zero;
        logic less;
    } alu_flags_t;

    typedef struct packed {
        instr_class_e cls;
        alu_op_e      alu_op;      // op for the execute step
        src_b_e       src_b;
        logic         branch_ne;
    } decoded_t;

    typedef struct packed {
        logic    pc_write;
        pc_src_e pc_src;
        logic    load_ir;
        logic    regs_ab_write;
        logic    alu_out_write;
        alu_op_e alu_op;
        src_a_e  src_a;
        src_b_e  src_b;
        logic    reg_write;
        wb_sel_e wb_sel;
        logic    epc_write;
    } ctrl_word_t;

endpackage

//--- rtl/instr_decoder.sv
`timescale 1ns/10ps

module instr_decoder import ctrl_pkg::*; (
    input  logic [31:0] instr,
    output decoded_t    decoded
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    always_comb begin
        decoded.cls       = CLS_ILLEGAL;
        decoded.alu_op    = ALU_NONE;
        decoded.src_b     = SRC_B_REG;
        decoded.branch_ne = 1'b0;
        case (opcode)
            OPC_OP: begin
                decoded.cls = CLS_ALU_REG;
                if (funct7 == 7'b0000000 && funct3 == F3_ADD_SUB) begin
                    decoded.alu_op = ALU_ADD;
                end else if (funct7 == F7_SUB && funct3 == F3_ADD_SUB) begin
                    decoded.alu_op = ALU_SUB;
                end else if (funct7 == 7'b0000000 && funct3 == F3_AND) begin
                    decoded.alu_op = ALU_AND;
                end else if (funct7 == 7'b0000000 && funct3 == F3_SLT) begin
                    decoded.alu_op = ALU_SLT;
                end else begin
                    decoded.cls = CLS_ILLEGAL;   // other R-type ops not supported
                end
            end
            OPC_OP_IMM: begin
                if (instr[31:7] == 25'd0) begin
                    decoded.cls = CLS_NOP;       // addi x0,x0,0
                end else if (funct3 == F3_ADD_SUB) begin
                    decoded.cls    = CLS_ALU_IMM;
                    decoded.alu_op = ALU_ADD;
                    decoded.src_b  = SRC_B_IMM;
                end
            end
            OPC_LUI: begin
                decoded.cls    = CLS_LUI;
                decoded.alu_op = ALU_ADD;
                decoded.src_b  = SRC_B_IMM;
            end
            OPC_BRANCH: begin
                decoded.alu_op = ALU_SUB;        // compare by subtract
                if (funct3 == F3_BEQ || funct3 == F3_BNE) begin
                    decoded.cls       = CLS_BRANCH;
                    decoded.branch_ne = (funct3 == F3_BNE);
                end
            end
            OPC_JAL:    decoded.cls = CLS_JAL;
            OPC_SYSTEM: decoded.cls = CLS_BREAK;
            default:    decoded.cls = CLS_ILLEGAL;
        endcase
    end

endmodule

//--- control/main_fsm.sv
`timescale 1ns/10ps

module main_fsm import ctrl_pkg::*; (
    input  logic       CLK,
    input  logic       RST,
    input  decoded_t   decoded,
    input  alu_flags_t flags,
    output state_e     state
);

    state_e next_state;

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            state <= ST_RESET;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            ST_RESET:      next_state = ST_FETCH_WAIT;
            ST_FETCH_WAIT: next_state = ST_FETCH;
            ST_FETCH:      next_state = ST_READ_REGS;
            ST_READ_REGS:  next_state = ST_EXECUTE;
            ST_EXECUTE: begin
                case (decoded.cls)
                    CLS_ALU_REG: begin
                        if (decoded.alu_op == ALU_SLT) begin
                            // slt result is picked here, not written from ALU-out
                            next_state = flags.less ? ST_WRITE_ONE : ST_WRITE_ZERO;
                        end else begin
                            next_state = ST_WRITE_ALU;
                        end
                    end
                    CLS_ALU_IMM: next_state = ST_WRITE_ALU;
                    CLS_LUI:     next_state = ST_WRITE_ALU;
                    CLS_BRANCH:  next_state = ST_FETCH_WAIT;
                    CLS_JAL:     next_state = ST_JAL_TARGET;
                    CLS_NOP:     next_state = ST_FETCH;       // skip the wait cycle
                    CLS_BREAK:   next_state = ST_HALT;
                    default:     next_state = ST_TRAP_VECTOR;
                endcase
            end
            ST_WRITE_ALU:   next_state = ST_FETCH_WAIT;
            ST_WRITE_ONE:   next_state = ST_FETCH_WAIT;
            ST_WRITE_ZERO:  next_state = ST_FETCH_WAIT;
            ST_JAL_TARGET:  next_state = ST_FETCH_WAIT;
            ST_TRAP_VECTOR: next_state = ST_FETCH_WAIT;
            ST_HALT:        next_state = ST_HALT;         // only RST leaves
            default:        next_state = ST_RESET;
        endcase
    end

endmodule

//--- control/ctrl_word_gen.sv
`timescale 1ns/10ps

module ctrl_word_gen import ctrl_pkg::*; (
    input  state_e     state,
    input  decoded_t   decoded,
    input  alu_flags_t flags,
    output ctrl_word_t ctrl
);

    always_comb begin
        ctrl = '0;                              // all enables off
        case (state)
            ST_FETCH: begin
                ctrl.load_ir  = 1'b1;
                ctrl.pc_write = 1'b1;
                ctrl.pc_src   = PC_ALU_RESULT;  // pc + 4
                ctrl.alu_op   = ALU_ADD;
                ctrl.src_a    = SRC_A_PC;
                ctrl.src_b    = SRC_B_FOUR;
            end
            ST_READ_REGS: begin
                // branch/jal target into ALU-out while A and B load
                ctrl.regs_ab_write = 1'b1;
                ctrl.alu_out_write = 1'b1;
                ctrl.alu_op        = ALU_ADD;
                ctrl.src_a         = SRC_A_PC;
                ctrl.src_b         = SRC_B_IMM;
            end
            ST_EXECUTE: begin
                case (decoded.cls)
                    CLS_ALU_REG, CLS_ALU_IMM: begin
                        ctrl.alu_out_write = 1'b1;
                        ctrl.alu_op        = decoded.alu_op;
                        ctrl.src_a         = SRC_A_REG;
                        ctrl.src_b         = decoded.src_b;
                    end
                    CLS_LUI: begin
                        ctrl.alu_out_write = 1'b1;
                        ctrl.alu_op        = ALU_ADD;   // 0 + imm
                        ctrl.src_a         = SRC_A_ZERO;
                        ctrl.src_b         = SRC_B_IMM;
                    end
                    CLS_BRANCH: begin
                        ctrl.alu_op   = ALU_SUB;
                        ctrl.src_a    = SRC_A_REG;
                        ctrl.src_b    = SRC_B_REG;
                        ctrl.pc_src   = PC_ALU_OUT;
                        ctrl.pc_write = flags.zero ^ decoded.branch_ne;  // taken
                    end
                    CLS_JAL: begin
                        ctrl.reg_write = 1'b1;      // link, pc already +4
                        ctrl.wb_sel    = WB_PC;
                    end
                    CLS_ILLEGAL: begin
                        ctrl.epc_write = 1'b1;
                    end
                    default: ;
                endcase
            end
            ST_WRITE_ALU: begin
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = WB_ALU_OUT;
            end
            ST_WRITE_ONE: begin
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = WB_ONE;
            end
            ST_WRITE_ZERO: begin
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = WB_ZERO;
            end
            ST_JAL_TARGET: begin
                ctrl.pc_write = 1'b1;
                ctrl.pc_src   = PC_ALU_OUT;     // target from read-regs step
            end
            ST_TRAP_VECTOR: begin
                ctrl.pc_write = 1'b1;
                ctrl.pc_src   = PC_TRAP_VECTOR;
            end
            default: ;
        endcase
    end

endmodule

//--- control/control_unit.sv
`timescale 1ns/10ps

module control_unit import ctrl_pkg::*; (
    input  logic        CLK,
    input  logic        RST,
    input  logic [31:0] instr,
    input  alu_flags_t  flags,
    output ctrl_word_t  ctrl
);

    decoded_t decoded;
    state_e   state;

    instr_decoder i_decoder (
        .instr   (instr),
        .decoded (decoded)
    );

    main_fsm i_fsm (
        .CLK     (CLK),
        .RST     (RST),
        .decoded (decoded),
        .flags   (flags),
        .state   (state)
    );

    ctrl_word_gen i_gen (
        .state   (state),
        .decoded (decoded),
        .flags   (flags),
        .ctrl    (ctrl)
    );

endmodule

//--- bench/control_unit_properties.sv
`timescale 1ns/10ps

module control_unit_properties import ctrl_pkg::*; (
    input logic       CLK,
    input logic       RST,
    input ctrl_word_t ctrl
);

    // fetch and write-back never share a cycle
    assert property (@(posedge CLK) disable iff (RST)
        !(ctrl.load_ir && ctrl.reg_write))
        else $error("load_ir and reg_write high together");

    // trap entry takes two cycles
    assert property (@(posedge CLK) disable iff (RST)
        ctrl.epc_write |=> (ctrl.pc_write && ctrl.pc_src == PC_TRAP_VECTOR))
        else $error("epc_write not followed by jump to trap vector");

    assert property (@(posedge CLK)
        $fell(RST) |-> !(ctrl.pc_write || ctrl.load_ir || ctrl.regs_ab_write
                         || ctrl.alu_out_write || ctrl.reg_write || ctrl.epc_write))
        else $error("enable high in first cycle after reset");

endmodule

bind control_unit control_unit_properties i_props (
    .CLK  (CLK),
    .RST  (RST),
    .ctrl (ctrl)
);

//--- bench/tb_control_unit.sv
`timescale 1ns/10ps

module tb_control_unit import ctrl_pkg::*; ();

    typedef struct packed {
        logic [31:0] instr;
        logic        zero;
        logic        less;
        logic [3:0]  interval;        // 0 means load_ir never returns
        alu_op_e     alu_op;
        src_a_e      src_a;
        src_b_e      src_b;
        logic        alu_out_write;
        logic        reg_write;
        logic        pc_write;
        logic        epc_write;
        logic        post_reg_write;  // cycle after execute
        wb_sel_e     post_wb;
        logic        post_pc_write;
        pc_src_e     post_pc_src;
    } row_t;

    logic        CLK;
    logic        RST;
    logic [31:0] instr;
    alu_flags_t  flags;
    ctrl_word_t  ctrl;

    row_t   rows[$];
    integer seed = 32'h3a483caa;
    int     mismatches = 0;
    int     failures = 0;
    int     cycles = 0;
    int     limit = 100000;

    control_unit i_dut (
        .CLK   (CLK),
        .RST   (RST),
        .instr (instr),
        .flags (flags),
        .ctrl  (ctrl)
    );

    initial CLK = 1'b0;
    always #2 CLK = ~CLK;

    always @(posedge CLK) begin
        cycles = cycles + 1;
        if (cycles >= limit) begin
            $display("timeout: run exceeded %0d cycles", limit);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {7'b0000000, rs2, rs1, f3, 5'b01000, OPC_BRANCH};  // offset +8
    endfunction

    function automatic logic any_enable(input ctrl_word_t c);
        return c.pc_write | c.load_ir | c.regs_ab_write | c.alu_out_write
             | c.reg_write | c.epc_write;
    endfunction

    task automatic add_row(input logic [31:0] ins, input logic zero, input logic less,
                           input logic [3:0] interval, input alu_op_e op,
                           input src_a_e sa, input src_b_e sb, input logic aow,
                           input logic rw, input logic pw, input logic ew,
                           input logic prw, input wb_sel_e pwb, input logic ppw,
                           input pc_src_e pps);
        row_t r;
        r = '{ins, zero, less, interval, op, sa, sb, aow, rw, pw, ew, prw, pwb, ppw, pps};
        rows.push_back(r);
    endtask

    task automatic check_field(input string name, input int row, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch row %0d %s: got %h expected %h", row, name, got, exp);
            mismatches++;
        end
    endtask

    // pc + 4 into the PC while the instruction loads
    task automatic check_fetch(input int i);
        check_field("fetch pc_write", i, 32'(ctrl.pc_write), 32'd1);
        check_field("fetch pc_src", i, 32'(ctrl.pc_src), 32'(PC_ALU_RESULT));
        check_field("fetch alu_op", i, 32'(ctrl.alu_op), 32'(ALU_ADD));
        check_field("fetch src_a", i, 32'(ctrl.src_a), 32'(SRC_A_PC));
        check_field("fetch src_b", i, 32'(ctrl.src_b), 32'(SRC_B_FOUR));
    endtask

    task automatic check_read_regs(input int i);
        check_field("read regs_ab_write", i, 32'(ctrl.regs_ab_write), 32'd1);
        check_field("read alu_out_write", i, 32'(ctrl.alu_out_write), 32'd1);
        check_field("read alu_op", i, 32'(ctrl.alu_op), 32'(ALU_ADD));
        check_field("read src_a", i, 32'(ctrl.src_a), 32'(SRC_A_PC));
        check_field("read src_b", i, 32'(ctrl.src_b), 32'(SRC_B_IMM));
        check_field("read pc_write", i, 32'(ctrl.pc_write), 32'd0);
        check_field("read load_ir", i, 32'(ctrl.load_ir), 32'd0);
    endtask

    task automatic check_execute(input int i);
        check_field("alu_op", i, 32'(ctrl.alu_op), 32'(rows[i].alu_op));
        check_field("src_a", i, 32'(ctrl.src_a), 32'(rows[i].src_a));
        check_field("src_b", i, 32'(ctrl.src_b), 32'(rows[i].src_b));
        check_field("alu_out_write", i, 32'(ctrl.alu_out_write), 32'(rows[i].alu_out_write));
        check_field("reg_write", i, 32'(ctrl.reg_write), 32'(rows[i].reg_write));
        check_field("pc_write", i, 32'(ctrl.pc_write), 32'(rows[i].pc_write));
        check_field("epc_write", i, 32'(ctrl.epc_write), 32'(rows[i].epc_write));
        if (rows[i].reg_write) begin
            check_field("wb_sel", i, 32'(ctrl.wb_sel), 32'(WB_PC));  // jal link
        end
        if (rows[i].pc_write) begin
            check_field("pc_src", i, 32'(ctrl.pc_src), 32'(PC_ALU_OUT));  // branch target
        end
    endtask

    task automatic check_after(input int i);
        check_field("post reg_write", i, 32'(ctrl.reg_write), 32'(rows[i].post_reg_write));
        check_field("post pc_write", i, 32'(ctrl.pc_write), 32'(rows[i].post_pc_write));
        if (rows[i].post_reg_write) begin
            check_field("post wb_sel", i, 32'(ctrl.wb_sel), 32'(rows[i].post_wb));
        end
        if (rows[i].post_pc_write) begin
            check_field("post pc_src", i, 32'(ctrl.pc_src), 32'(rows[i].post_pc_src));
        end
    endtask

    initial begin
        int          k;
        logic        seen;
        logic        lost;
        int          max_k;
        logic [31:0] rnd;

        RST   = 1'b1;
        instr = 32'h0;
        flags = '0;

        add_row(r_type(7'h00, F3_ADD_SUB, 5'd3, 5'd1, 5'd2), 0, 0, 5, ALU_ADD, SRC_A_REG,
                SRC_B_REG, 1, 0, 0, 0, 1, WB_ALU_OUT, 0, PC_ALU_OUT);
        add_row(r_type(F7_SUB, F3_ADD_SUB, 5'd4, 5'd2, 5'd3), 0, 0, 5, ALU_SUB, SRC_A_REG,
                SRC_B_REG, 1, 0, 0, 0, 1, WB_ALU_OUT, 0, PC_ALU_OUT);
        add_row(r_type(7'h00, F3_AND, 5'd5, 5'd6, 5'd7), 0, 0, 5, ALU_AND, SRC_A_REG,
                SRC_B_REG, 1, 0, 0, 0, 1, WB_ALU_OUT, 0, PC_ALU_OUT);
        add_row(r_type(7'h00, F3_SLT, 5'd8, 5'd1, 5'd2), 0, 1, 5, ALU_SLT, SRC_A_REG,
                SRC_B_REG, 1, 0, 0, 0, 1, WB_ONE, 0, PC_ALU_OUT);
        add_row(r_type(7'h00, F3_SLT, 5'd9, 5'd1, 5'd2), 0, 0, 5, ALU_SLT, SRC_A_REG,
                SRC_B_REG, 1, 0, 0, 0, 1, WB_ZERO, 0, PC_ALU_OUT);
        add_row({12'd12, 5'd1, F3_ADD_SUB, 5'd5, OPC_OP_IMM}, 0, 0, 5, ALU_ADD, SRC_A_REG,
                SRC_B_IMM, 1, 0, 0, 0, 1, WB_ALU_OUT, 0, PC_ALU_OUT);
        add_row({20'h12345, 5'd7, OPC_LUI}, 0, 0, 5, ALU_ADD, SRC_A_ZERO,
                SRC_B_IMM, 1, 0, 0, 0, 1, WB_ALU_OUT, 0, PC_ALU_OUT);
        add_row(b_type(F3_BEQ, 5'd1, 5'd2), 1, 0, 4, ALU_SUB, SRC_A_REG, SRC_B_REG,
                0, 0, 1, 0, 0, WB_ALU_OUT, 0, PC_ALU_OUT);
        add_row(b_type(F3_BEQ, 5'd1, 5'd2), 0, 0, 4, ALU_SUB, SRC_A_REG, SRC_B_REG,
                0, 0, 0, 0, 0, WB_ALU_OUT, 0, PC_ALU_OUT);
        add_row(b_type(F3_BNE, 5'd3, 5'd4), 1, 0, 4, ALU_SUB, SRC_A_REG, SRC_B_REG,
                0, 0, 0, 0, 0, WB_ALU_OUT, 0, PC_ALU_OUT);
        add_row(b_type(F3_BNE, 5'd3, 5'd4), 0, 1, 4, ALU_SUB, SRC_A_REG, SRC_B_REG,
                0, 0, 1, 0, 0, WB_ALU_OUT, 0, PC_ALU_OUT);
        add_row({20'h00100, 5'd1, OPC_JAL}, 0, 0, 5, ALU_NONE, SRC_A_PC, SRC_B_REG,
                0, 1, 0, 0, 0, WB_ALU_OUT, 1, PC_ALU_OUT);
        add_row(32'h00000013, 0, 0, 3, ALU_NONE, SRC_A_PC, SRC_B_REG,
                0, 0, 0, 0, 0, WB_ALU_OUT, 0, PC_ALU_OUT);
        add_row(32'h00002003, 0, 0, 5, ALU_NONE, SRC_A_PC, SRC_B_REG,
                0, 0, 0, 1, 0, WB_ALU_OUT, 1, PC_TRAP_VECTOR);  // load opcode is illegal
        rnd = $random(seed);
        add_row(r_type(7'h00, F3_ADD_SUB, rnd[4:0], rnd[9:5], rnd[14:10]), 0, 0, 5, ALU_ADD,
                SRC_A_REG, SRC_B_REG, 1, 0, 0, 0, 1, WB_ALU_OUT, 0, PC_ALU_OUT);
        rnd = $random(seed);
        add_row(r_type(F7_SUB, F3_ADD_SUB, rnd[4:0], rnd[9:5], rnd[14:10]), 0, 0, 5, ALU_SUB,
                SRC_A_REG, SRC_B_REG, 1, 0, 0, 0, 1, WB_ALU_OUT, 0, PC_ALU_OUT);
        rnd = $random(seed);
        add_row({rnd[31:20], rnd[9:5], F3_ADD_SUB, {rnd[4:1], 1'b1}, OPC_OP_IMM}, 0, 0, 5,
                ALU_ADD, SRC_A_REG, SRC_B_IMM, 1, 0, 0, 0, 1, WB_ALU_OUT, 0, PC_ALU_OUT);
        add_row(32'h00100073, 0, 0, 0, ALU_NONE, SRC_A_PC, SRC_B_REG,
                0, 0, 0, 0, 0, WB_ALU_OUT, 0, PC_ALU_OUT);   // ebreak
        limit = rows.size() * 6 + 40;

        repeat (10) begin
            @(negedge CLK);
            if (any_enable(ctrl)) begin
                $display("an enable was high while reset was asserted");
                failures++;
            end
        end
        RST = 1'b0;

        k = 0;
        seen = 1'b0;
        while (!seen) begin
            @(negedge CLK);
            k++;
            if (ctrl.load_ir) begin
                seen = 1'b1;
            end else if (any_enable(ctrl)) begin
                $display("an enable was high before the first fetch");
                failures++;
            end
        end
        check_field("first load_ir delay", -1, 32'(k), 32'd2);
        check_fetch(-1);

        lost = 1'b0;
        for (int i = 0; i < rows.size() && !lost; i++) begin
            instr      = rows[i].instr;   // driven right after the fetch cycle
            flags.zero = rows[i].zero;
            flags.less = rows[i].less;
            max_k = (rows[i].interval == 0) ? 20 : 8;
            k = 0;
            seen = 1'b0;
            while (!seen && k < max_k) begin
                @(negedge CLK);
                k++;
                if (k == 1) check_read_regs(i);
                if (k == 2) check_execute(i);
                if (k == 3 && rows[i].interval == 5) check_after(i);
                if (ctrl.load_ir) begin
                    seen = 1'b1;
                    check_fetch(i);
                end
            end
            if (rows[i].interval == 0) begin
                if (seen) begin
                    $display("load_ir rose again after ebreak in row %0d", i);
                    failures++;
                end
            end else if (!seen) begin
                $display("row %0d: no load_ir within %0d cycles", i, max_k);
                failures++;
                lost = 1'b1;
            end else begin
                check_field("load_ir interval", i, 32'(k), 32'(rows[i].interval));
            end
        end

        $display("summary: %0d mismatches, %0d other errors", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- verilog.f
common/ctrl_pkg.sv
rtl/instr_decoder.sv
control/main_fsm.sv
control/ctrl_word_gen.sv
control/control_unit.sv
bench/control_unit_properties.sv
bench/tb_control_unit.sv

//--- run.sh
#!/bin/sh
# Build and run the control unit testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module tb_control_unit -o sim_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "ALL CHECKS PASSED"; then
    exit 0
fi
exit 1
